// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cfir_tb
FILELIST  ?= cfir_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

SOURCES := $(wildcard *.sv *.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cfir_accumulator.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cfir_defines.svh"

module cfir_accumulator (
  input  logic                          clk,
  input  logic                          RST,
  input  logic                          first_i,
  input  logic                          last_i,
  input  cfir_pkg::prod_t               prod_i_i [`CFIR_LANES],
  input  cfir_pkg::prod_t               prod_q_i [`CFIR_LANES],
  output logic                          push_out_o,
  output logic signed [`CFIR_OUT_W-1:0] fi_o,
  output logic signed [`CFIR_OUT_W-1:0] fq_o
);

  localparam int LANES     = `CFIR_LANES;
  localparam int FIRST_DLY = 4;
  localparam int LAST_DLY  = 5;
  localparam int OUT_LSB   = `CFIR_OUT_SHIFT;
  localparam int OUT_MSB   = `CFIR_OUT_W + `CFIR_OUT_SHIFT - 1;

  logic [FIRST_DLY-1:0] first_pipe;
  logic [LAST_DLY-1:0]  last_pipe;

  cfir_pkg::acc_t sum_i_c;
  cfir_pkg::acc_t sum_q_c;
  cfir_pkg::acc_t lane_i;
  cfir_pkg::acc_t lane_q;
  cfir_pkg::acc_t acc_i;
  cfir_pkg::acc_t acc_q;
  cfir_pkg::acc_t rnd_i;
  cfir_pkg::acc_t rnd_q;

  // Strobes follow the datapath latency
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      first_pipe <= '0;
      last_pipe  <= '0;
      push_out_o <= 1'b0;
    end
    else
    begin
      first_pipe <= {first_pipe[FIRST_DLY-2:0], first_i};
      last_pipe  <= {last_pipe[LAST_DLY-2:0], last_i};
      push_out_o <= last_pipe[LAST_DLY-1];
    end
  end

  always_comb
  begin
    sum_i_c = '0;
    sum_q_c = '0;
    for (int j = 0; j < LANES; j++)
    begin
      sum_i_c = sum_i_c + cfir_pkg::acc_t'(prod_i_i[j] >>> `CFIR_PROD_SHIFT);
      sum_q_c = sum_q_c + cfir_pkg::acc_t'(prod_q_i[j] >>> `CFIR_PROD_SHIFT);
    end
  end

  always_ff @(posedge clk)
  begin
    lane_i <= sum_i_c;
    lane_q <= sum_q_c;
    if (first_pipe[FIRST_DLY-1])
    begin
      acc_i <= lane_i;
      acc_q <= lane_q;
    end
    else
    begin
      acc_i <= acc_i + lane_i;
      acc_q <= acc_q + lane_q;
    end
  end

  // Negative values get a bias before truncation
  assign rnd_i = acc_i + (acc_i[`CFIR_ACC_W-1] ? cfir_pkg::acc_t'(`CFIR_NEG_ROUND) : '0);
  assign rnd_q = acc_q + (acc_q[`CFIR_ACC_W-1] ? cfir_pkg::acc_t'(`CFIR_NEG_ROUND) : '0);

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      fi_o <= '0;
      fq_o <= '0;
    end
    else if (last_pipe[LAST_DLY-1])
    begin
      fi_o <= rnd_i[OUT_MSB:OUT_LSB];
      fq_o <= rnd_q[OUT_MSB:OUT_LSB];
    end
  end

endmodule

`default_nettype wire

// ==== cfir_cmult.sv ====
`timescale 1ns/10ps
`default_nettype none

module cfir_cmult (
  input  logic              clk,
  input  logic              RST,
  input  cfir_pkg::presum_t data_i_i,
  input  cfir_pkg::presum_t data_q_i,
  input  cfir_pkg::coef_t   coef_i_i,
  input  cfir_pkg::coef_t   coef_q_i,
  output cfir_pkg::prod_t   prod_i_o,
  output cfir_pkg::prod_t   prod_q_o
);

  // (a + jb)(c + jd) partial products
  cfir_pkg::prod_t ac;
  cfir_pkg::prod_t bd;
  cfir_pkg::prod_t bc;
  cfir_pkg::prod_t ad;

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      ac       <= '0;
      bd       <= '0;
      bc       <= '0;
      ad       <= '0;
      prod_i_o <= '0;
      prod_q_o <= '0;
    end
    else
    begin
      ac       <= data_i_i * coef_i_i;
      bd       <= data_q_i * coef_q_i;
      bc       <= data_q_i * coef_i_i;
      ad       <= data_i_i * coef_q_i;
      prod_i_o <= ac - bd;
      prod_q_o <= bc + ad;
    end
  end

endmodule

`default_nettype wire

// ==== cfir_coef_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cfir_defines.svh"

module cfir_coef_bank (
  input  logic                         clk,
  input  logic                         RST,
  input  logic                         wr_i,
  input  logic [`CFIR_COEF_ADDR_W-1:0] addr_i,
  input  cfir_pkg::coef_t              wr_i_i,
  input  cfir_pkg::coef_t              wr_q_i,
  input  logic                         accept_i,
  input  cfir_pkg::phase_e             phase_i,
  output cfir_pkg::coef_t              coef_i_o [`CFIR_LANES],
  output cfir_pkg::coef_t              coef_q_o [`CFIR_LANES]
);

  localparam int COEFS = `CFIR_COEFS;
  localparam int LANES = `CFIR_LANES;

  cfir_pkg::coef_t shadow_i [COEFS];
  cfir_pkg::coef_t shadow_q [COEFS];
  cfir_pkg::coef_t active_i [COEFS];
  cfir_pkg::coef_t active_q [COEFS];

  logic [COEFS-1:0] wr_sel;
  int               sel_base;

  // Out of range addresses match no entry
  always_comb
  begin
    for (int k = 0; k < COEFS; k++)
      wr_sel[k] = wr_i && (addr_i == k);
  end

  always_comb
    sel_base = int'(phase_i) * LANES;

  ////////////////////////////////////////////////////////////////////////////
  // Shadow and active banks
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < COEFS; k++)
      begin
        shadow_i[k] <= '0;
        shadow_q[k] <= '0;
        active_i[k] <= '0;
        active_q[k] <= '0;
      end
    end
    else
    begin
      for (int k = 0; k < COEFS; k++)
      begin
        if (wr_sel[k])
        begin
          shadow_i[k] <= wr_i_i;
          shadow_q[k] <= wr_q_i;
        end
        // Copy sees a write made in the same cycle
        if (accept_i)
        begin
          active_i[k] <= wr_sel[k] ? wr_i_i : shadow_i[k];
          active_q[k] <= wr_sel[k] ? wr_q_i : shadow_q[k];
        end
      end
    end
  end

  // Lines up with the registered pre-sums
  always_ff @(posedge clk)
  begin
    for (int j = 0; j < LANES; j++)
    begin
      coef_i_o[j] <= active_i[sel_base + j];
      coef_q_o[j] <= active_q[sel_base + j];
    end
  end

endmodule

`default_nettype wire

// ==== cfir_defines.svh ====
`ifndef CFIR_DEFINES_SVH
`define CFIR_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////
`define CFIR_SAMPLE_W     24
`define CFIR_COEF_W       27
`define CFIR_PRESUM_W     25
`define CFIR_PROD_W       52
`define CFIR_ACC_W        38
`define CFIR_OUT_W        32

////////////////////////////////////////////////////////////////////////////
// Filter shape
////////////////////////////////////////////////////////////////////////////
`define CFIR_TAPS         29
`define CFIR_COEFS        15
`define CFIR_COEF_ADDR_W  5
`define CFIR_LANES        5
`define CFIR_FIFO_DEPTH   4

// Scaling and rounding
`define CFIR_PROD_SHIFT   18
`define CFIR_OUT_SHIFT    5
`define CFIR_NEG_ROUND    8

`endif

// ==== cfir_pkg.sv ====
`default_nettype none

`include "cfir_defines.svh"

package cfir_pkg;

  typedef logic signed [`CFIR_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`CFIR_COEF_W-1:0]   coef_t;
  typedef logic signed [`CFIR_PRESUM_W-1:0] presum_t;
  typedef logic signed [`CFIR_PROD_W-1:0]   prod_t;
  typedef logic signed [`CFIR_ACC_W-1:0]    acc_t;

  // Sequencer states with three multiply phases per sample
  typedef enum logic [1:0] {ST_IDLE, ST_MUL_0, ST_MUL_1, ST_MUL_2} seq_state_e;

  typedef enum logic [1:0] {PH_0, PH_1, PH_2} phase_e;

endpackage

`default_nettype wire

// ==== cfir_sample_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cfir_defines.svh"

module cfir_sample_fifo (
  input  logic              clk,
  input  logic              RST,
  input  logic              push_i,
  input  cfir_pkg::sample_t samp_i_i,
  input  cfir_pkg::sample_t samp_q_i,
  input  logic              pop_i,
  output logic              full_o,
  output logic              empty_o,
  output logic              accept_o,
  output cfir_pkg::sample_t head_i_o,
  output cfir_pkg::sample_t head_q_o
);

  localparam int DEPTH = `CFIR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  cfir_pkg::sample_t mem_i [DEPTH];
  cfir_pkg::sample_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;

  // A push while full is dropped
  assign accept_o   = push_i & ~full_o;
  assign wr_ptr_nxt = wr_ptr + 1'b1;
  assign rd_ptr_nxt = rd_ptr + 1'b1;

  assign head_i_o = mem_i[rd_ptr];
  assign head_q_o = mem_q[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (accept_o)
    begin
      mem_i[wr_ptr] <= samp_i_i;
      mem_q[wr_ptr] <= samp_q_i;
    end
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      full_o  <= 1'b0;
      empty_o <= 1'b1;
    end
    else
    begin
      case ({accept_o, pop_i})
        2'b10:
        begin
          wr_ptr  <= wr_ptr_nxt;
          empty_o <= 1'b0;
          full_o  <= (wr_ptr_nxt == rd_ptr);
        end
        2'b01:
        begin
          rd_ptr  <= rd_ptr_nxt;
          full_o  <= 1'b0;
          empty_o <= (rd_ptr_nxt == wr_ptr);
        end
        // Occupancy unchanged
        2'b11:
        begin
          wr_ptr <= wr_ptr_nxt;
          rd_ptr <= rd_ptr_nxt;
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== cfir_tap_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cfir_defines.svh"

module cfir_tap_sequencer (
  input  logic              clk,
  input  logic              RST,
  input  logic              empty_i,
  input  cfir_pkg::sample_t head_i_i,
  input  cfir_pkg::sample_t head_q_i,
  output logic              pop_o,
  output cfir_pkg::phase_e  phase_o,
  output logic              first_o,
  output logic              last_o,
  output cfir_pkg::presum_t presum_i_o [`CFIR_LANES],
  output cfir_pkg::presum_t presum_q_o [`CFIR_LANES]
);

  localparam int TAPS   = `CFIR_TAPS;
  localparam int LANES  = `CFIR_LANES;
  localparam int CENTER = (`CFIR_TAPS - 1) / 2;

  cfir_pkg::seq_state_e state;
  cfir_pkg::seq_state_e state_nxt;

  cfir_pkg::sample_t dl_i [TAPS];
  cfir_pkg::sample_t dl_q [TAPS];
  cfir_pkg::sample_t near_i [LANES];
  cfir_pkg::sample_t near_q [LANES];
  cfir_pkg::sample_t far_i [LANES];
  cfir_pkg::sample_t far_q [LANES];

  int tap_base;

  ////////////////////////////////////////////////////////////////////////////
  // Phase FSM
  ////////////////////////////////////////////////////////////////////////////
  assign pop_o = ((state == cfir_pkg::ST_IDLE) || (state == cfir_pkg::ST_MUL_2)) && !empty_i;
  assign first_o = (state == cfir_pkg::ST_MUL_0);
  assign last_o  = (state == cfir_pkg::ST_MUL_2);

  always_comb
  begin
    case (state)
      cfir_pkg::ST_MUL_0: state_nxt = cfir_pkg::ST_MUL_1;
      cfir_pkg::ST_MUL_1: state_nxt = cfir_pkg::ST_MUL_2;
      default:            state_nxt = pop_o ? cfir_pkg::ST_MUL_0 : cfir_pkg::ST_IDLE;
    endcase
  end

  always_comb
  begin
    case (state)
      cfir_pkg::ST_MUL_1: phase_o = cfir_pkg::PH_1;
      cfir_pkg::ST_MUL_2: phase_o = cfir_pkg::PH_2;
      default:            phase_o = cfir_pkg::PH_0;
    endcase
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
      state <= cfir_pkg::ST_IDLE;
    else
      state <= state_nxt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Delay line with the newest sample at index 0
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < TAPS; k++)
      begin
        dl_i[k] <= '0;
        dl_q[k] <= '0;
      end
    end
    else if (pop_o)
    begin
      dl_i[0] <= head_i_i;
      dl_q[0] <= head_q_i;
      for (int k = 1; k < TAPS; k++)
      begin
        dl_i[k] <= dl_i[k-1];
        dl_q[k] <= dl_q[k-1];
      end
    end
  end

  // Tap k pairs with tap 28-k; the centre tap has no partner
  always_comb
    tap_base = int'(phase_o) * LANES;

  always_comb
  begin
    for (int j = 0; j < LANES; j++)
    begin
      near_i[j] = dl_i[tap_base + j];
      near_q[j] = dl_q[tap_base + j];
      far_i[j]  = (tap_base + j == CENTER) ? '0 : dl_i[TAPS - 1 - tap_base - j];
      far_q[j]  = (tap_base + j == CENTER) ? '0 : dl_q[TAPS - 1 - tap_base - j];
    end
  end

  always_ff @(posedge clk)
  begin
    for (int j = 0; j < LANES; j++)
    begin
      presum_i_o[j] <= cfir_pkg::presum_t'(near_i[j]) + cfir_pkg::presum_t'(far_i[j]);
      presum_q_o[j] <= cfir_pkg::presum_t'(near_q[j]) + cfir_pkg::presum_t'(far_q[j]);
    end
  end

endmodule

`default_nettype wire

// ==== cfir_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cfir_defines.svh"

module cfir_tb;

  localparam int TAPS        = `CFIR_TAPS;
  localparam int COEFS       = `CFIR_COEFS;
  localparam int CENTER      = (`CFIR_TAPS - 1) / 2;
  localparam int SEED        = 32'h474b_056e;
  localparam int RAND_COUNT  = 120;
  localparam int BP_COUNT    = 60;
  localparam int UPD_COUNT   = 40;
  localparam int MAX_GAP     = 4;
  localparam int IDLE_CYCLES = 40;
  localparam int DRAIN_LIMIT = 200;
  localparam int MARGIN      = 1000;
  localparam int TOTAL_SAMPLES   = TAPS + RAND_COUNT + BP_COUNT + UPD_COUNT;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 3 + RAND_COUNT * MAX_GAP
                                   + 3 * (COEFS + 2) + IDLE_CYCLES + MARGIN;

  typedef logic [`CFIR_OUT_W-1:0] out_t;

  logic                                clk;
  logic                                RST;
  logic                                push_in;
  cfir_pkg::sample_t                   samp_i;
  cfir_pkg::sample_t                   samp_q;
  logic                                push_coef;
  logic [`CFIR_COEF_ADDR_W-1:0]        coef_addr;
  cfir_pkg::coef_t                     coef_i;
  cfir_pkg::coef_t                     coef_q;
  logic                                stop_in;
  logic                                push_out;
  logic signed [`CFIR_OUT_W-1:0]       fi;
  logic signed [`CFIR_OUT_W-1:0]       fq;

  // Reference model state
  longint dl_i [TAPS];
  longint dl_q [TAPS];
  longint shadow_i [COEFS];
  longint shadow_q [COEFS];
  longint active_i [COEFS];
  longint active_q [COEFS];

  out_t exp_i_q [$];
  out_t exp_q_q [$];
  out_t got_i_q [$];
  out_t got_q_q [$];
  out_t want_i;
  out_t want_q;

  int errors;
  int tests_run;
  int accepted;
  int out_count;
  bit saw_full;

  cfir_top i_cfir_top (
    .clk         (clk),
    .RST         (RST),
    .push_in_i   (push_in),
    .samp_i_i    (samp_i),
    .samp_q_i    (samp_q),
    .push_coef_i (push_coef),
    .coef_addr_i (coef_addr),
    .coef_i_i    (coef_i),
    .coef_q_i    (coef_q),
    .stop_in_o   (stop_in),
    .push_out_o  (push_out),
    .fi_o        (fi),
    .fq_o        (fq)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Complex product difference and sum wrap at the product width
  function automatic longint wrap_prod(input longint v);
    return (v <<< (64 - `CFIR_PROD_W)) >>> (64 - `CFIR_PROD_W);
  endfunction

  function automatic out_t round_out(input longint acc);
    longint r;
    r = (acc < 0) ? acc + `CFIR_NEG_ROUND : acc;
    return out_t'(r >>> `CFIR_OUT_SHIFT);
  endfunction

  task automatic model_accept(input cfir_pkg::sample_t si, input cfir_pkg::sample_t sq);
    longint a;
    longint b;
    longint acc_i;
    longint acc_q;
    for (int k = 0; k < COEFS; k++)
    begin
      active_i[k] = shadow_i[k];
      active_q[k] = shadow_q[k];
    end
    for (int k = TAPS - 1; k > 0; k--)
    begin
      dl_i[k] = dl_i[k-1];
      dl_q[k] = dl_q[k-1];
    end
    dl_i[0] = si;
    dl_q[0] = sq;
    acc_i = 0;
    acc_q = 0;
    // Mirrored taps share a coefficient and the centre tap stands alone
    for (int k = 0; k < COEFS; k++)
    begin
      a = dl_i[k] + ((k == CENTER) ? 0 : dl_i[TAPS-1-k]);
      b = dl_q[k] + ((k == CENTER) ? 0 : dl_q[TAPS-1-k]);
      acc_i += wrap_prod(a * active_i[k] - b * active_q[k]) >>> `CFIR_PROD_SHIFT;
      acc_q += wrap_prod(b * active_i[k] + a * active_q[k]) >>> `CFIR_PROD_SHIFT;
    end
    exp_i_q.push_back(round_out(acc_i));
    exp_q_q.push_back(round_out(acc_q));
    accepted++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////
  task automatic write_coef(input int addr, input cfir_pkg::coef_t ci,
                            input cfir_pkg::coef_t cq);
    @(negedge clk);
    push_in   = 1'b0;
    push_coef = 1'b1;
    coef_addr = addr[`CFIR_COEF_ADDR_W-1:0];
    coef_i    = ci;
    coef_q    = cq;
    if (addr < COEFS)
    begin
      shadow_i[addr] = ci;
      shadow_q[addr] = cq;
    end
  endtask

  // Holds the sample until the FIFO takes it
  task automatic push_sample(input cfir_pkg::sample_t si, input cfir_pkg::sample_t sq);
    bit done;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      push_coef = 1'b0;
      push_in   = 1'b1;
      samp_i    = si;
      samp_q    = sq;
      if (stop_in)
        saw_full = 1'b1;
      else
      begin
        model_accept(si, sq);
        done = 1'b1;
      end
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      push_in   = 1'b0;
      push_coef = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    idle(1);
    while (exp_i_q.size() > 0 && waited < DRAIN_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    assert (exp_i_q.size() == 0)
    else
    begin
      $display("outputs did not drain, %0d still expected", exp_i_q.size());
      errors++;
    end
    // Room for a stray extra strobe to show up
    idle(4);
  endtask

  task automatic end_test(input string name, input int err0);
    tests_run++;
    $display("test %s finished with %0d errors", name, errors - err0);
  endtask

  task automatic finish_run();
    $display("tests %0d, samples accepted %0d, outputs checked %0d, errors %0d",
             tests_run, accepted, out_count, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // Output monitor
  always @(negedge clk)
  begin
    if (!RST && push_out)
    begin
      out_count++;
      got_i_q.push_back(fi);
      got_q_q.push_back(fq);
      assert (exp_i_q.size() > 0)
      else
      begin
        $display("output strobe arrived with no expected value queued");
        errors++;
      end
      if (exp_i_q.size() > 0)
      begin
        want_i = exp_i_q.pop_front();
        want_q = exp_q_q.pop_front();
        assert (fi == want_i)
        else
        begin
          $display("error: fi_o = %h, expected %h", fi, want_i);
          errors++;
        end
        assert (fq == want_q)
        else
        begin
          $display("error: fq_o = %h, expected %h", fq, want_q);
          errors++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_reset();
    int err0;
    int out0;
    err0 = errors;
    @(negedge clk);
    assert (push_out == 1'b0)
    else
    begin
      $display("error: push_out_o = %h after reset, expected 0", push_out);
      errors++;
    end
    assert (stop_in == 1'b0)
    else
    begin
      $display("error: stop_in_o = %h after reset, expected 0", stop_in);
      errors++;
    end
    out0 = out_count;
    idle(IDLE_CYCLES);
    assert (out_count == out0)
    else
    begin
      $display("outputs appeared although no sample was pushed");
      errors++;
    end
    end_test("reset and idle", err0);
  endtask

  task automatic test_impulse();
    int err0;
    err0 = errors;
    got_i_q.delete();
    got_q_q.delete();
    for (int k = 0; k < COEFS; k++)
      write_coef(k, cfir_pkg::coef_t'((k + 1) * 8192), cfir_pkg::coef_t'(-(k + 1) * 3000));
    idle(1);
    push_sample(24'sh10_0000, 24'sh08_0000);
    for (int n = 1; n < TAPS; n++)
      push_sample('0, '0);
    wait_drain();
    assert (got_i_q.size() == TAPS)
    else
    begin
      $display("impulse gave %0d outputs instead of %0d", got_i_q.size(), TAPS);
      errors++;
    end
    if (got_i_q.size() == TAPS)
    begin
      for (int n = 0; n < CENTER; n++)
      begin
        assert (got_i_q[n] == got_i_q[TAPS-1-n] && got_q_q[n] == got_q_q[TAPS-1-n])
        else
        begin
          $display("error: fi_o/fq_o at output %0d = %h/%h, mirror output gives %h/%h",
                   n, got_i_q[n], got_q_q[n], got_i_q[TAPS-1-n], got_q_q[TAPS-1-n]);
          errors++;
        end
      end
    end
    end_test("impulse response", err0);
  endtask

  task automatic test_random();
    int err0;
    err0 = errors;
    for (int k = 0; k < COEFS; k++)
      write_coef(k, cfir_pkg::coef_t'($urandom()), cfir_pkg::coef_t'($urandom()));
    idle(1);
    for (int n = 0; n < RAND_COUNT; n++)
    begin
      push_sample(cfir_pkg::sample_t'($urandom()), cfir_pkg::sample_t'($urandom()));
      idle($urandom_range(MAX_GAP, 0));
    end
    wait_drain();
    end_test("random samples", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    int acc0;
    int out0;
    err0 = errors;
    acc0 = accepted;
    out0 = out_count;
    saw_full = 1'b0;
    for (int n = 0; n < BP_COUNT; n++)
      push_sample(cfir_pkg::sample_t'($urandom()), cfir_pkg::sample_t'($urandom()));
    wait_drain();
    assert (saw_full)
    else
    begin
      $display("stop_in_o never rose while pushing every cycle");
      errors++;
    end
    assert (out_count - out0 == accepted - acc0)
    else
    begin
      $display("error: output count %h, accepted count %h", out_count - out0, accepted - acc0);
      errors++;
    end
    end_test("back-pressure", err0);
  endtask

  task automatic test_coef_update();
    int err0;
    err0 = errors;
    for (int k = 0; k < COEFS; k++)
      write_coef(k, cfir_pkg::coef_t'($urandom()), cfir_pkg::coef_t'($urandom()));
    // Address 15 has no entry
    write_coef(COEFS, cfir_pkg::coef_t'($urandom()), cfir_pkg::coef_t'($urandom()));
    idle(1);
    for (int n = 0; n < UPD_COUNT; n++)
    begin
      push_sample(cfir_pkg::sample_t'($urandom()), cfir_pkg::sample_t'($urandom()));
      idle(1);
    end
    wait_drain();
    end_test("coefficient update", err0);
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    errors++;
    finish_run();
  end

  initial
  begin
    void'($urandom(SEED));
    errors    = 0;
    tests_run = 0;
    accepted  = 0;
    out_count = 0;
    saw_full  = 1'b0;
    RST       = 1'b1;
    push_in   = 1'b0;
    samp_i    = '0;
    samp_q    = '0;
    push_coef = 1'b0;
    coef_addr = '0;
    coef_i    = '0;
    coef_q    = '0;
    for (int k = 0; k < TAPS; k++)
    begin
      dl_i[k] = 0;
      dl_q[k] = 0;
    end
    for (int k = 0; k < COEFS; k++)
    begin
      shadow_i[k] = 0;
      shadow_q[k] = 0;
      active_i[k] = 0;
      active_q[k] = 0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    RST = 1'b0;
    test_reset();
    test_impulse();
    test_random();
    test_backpressure();
    test_coef_update();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== cfir_top.f ====
+incdir+.
cfir_pkg.sv
cfir_sample_fifo.sv
cfir_coef_bank.sv
cfir_tap_sequencer.sv
cfir_cmult.sv
cfir_accumulator.sv
cfir_top.sv
cfir_tb.sv

// ==== cfir_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cfir_defines.svh"

module cfir_top (
  input  logic                          clk,
  input  logic                          RST,
  input  logic                          push_in_i,
  input  cfir_pkg::sample_t             samp_i_i,
  input  cfir_pkg::sample_t             samp_q_i,
  input  logic                          push_coef_i,
  input  logic [`CFIR_COEF_ADDR_W-1:0]  coef_addr_i,
  input  cfir_pkg::coef_t               coef_i_i,
  input  cfir_pkg::coef_t               coef_q_i,
  output logic                          stop_in_o,
  output logic                          push_out_o,
  output logic signed [`CFIR_OUT_W-1:0] fi_o,
  output logic signed [`CFIR_OUT_W-1:0] fq_o
);

  logic              accept;
  logic              fifo_empty;
  logic              pop;
  logic              first;
  logic              last;
  cfir_pkg::sample_t head_i;
  cfir_pkg::sample_t head_q;
  cfir_pkg::phase_e  phase;

  cfir_pkg::presum_t presum_i [`CFIR_LANES];
  cfir_pkg::presum_t presum_q [`CFIR_LANES];
  cfir_pkg::coef_t   coef_i [`CFIR_LANES];
  cfir_pkg::coef_t   coef_q [`CFIR_LANES];
  cfir_pkg::prod_t   prod_i [`CFIR_LANES];
  cfir_pkg::prod_t   prod_q [`CFIR_LANES];

  cfir_sample_fifo i_fifo (
    .clk      (clk),
    .RST      (RST),
    .push_i   (push_in_i),
    .samp_i_i (samp_i_i),
    .samp_q_i (samp_q_i),
    .pop_i    (pop),
    .full_o   (stop_in_o),
    .empty_o  (fifo_empty),
    .accept_o (accept),
    .head_i_o (head_i),
    .head_q_o (head_q)
  );

  cfir_coef_bank i_coef_bank (
    .clk      (clk),
    .RST      (RST),
    .wr_i     (push_coef_i),
    .addr_i   (coef_addr_i),
    .wr_i_i   (coef_i_i),
    .wr_q_i   (coef_q_i),
    .accept_i (accept),
    .phase_i  (phase),
    .coef_i_o (coef_i),
    .coef_q_o (coef_q)
  );

  cfir_tap_sequencer i_sequencer (
    .clk        (clk),
    .RST        (RST),
    .empty_i    (fifo_empty),
    .head_i_i   (head_i),
    .head_q_i   (head_q),
    .pop_o      (pop),
    .phase_o    (phase),
    .first_o    (first),
    .last_o     (last),
    .presum_i_o (presum_i),
    .presum_q_o (presum_q)
  );

  // One multiplier per lane
  for (genvar j = 0; j < `CFIR_LANES; j++)
  begin : g_lane
    cfir_cmult i_cmult (
      .clk      (clk),
      .RST      (RST),
      .data_i_i (presum_i[j]),
      .data_q_i (presum_q[j]),
      .coef_i_i (coef_i[j]),
      .coef_q_i (coef_q[j]),
      .prod_i_o (prod_i[j]),
      .prod_q_o (prod_q[j])
    );
  end

  cfir_accumulator i_accumulator (
    .clk        (clk),
    .RST        (RST),
    .first_i    (first),
    .last_i     (last),
    .prod_i_i   (prod_i),
    .prod_q_i   (prod_q),
    .push_out_o (push_out_o),
    .fi_o       (fi_o),
    .fq_o       (fq_o)
  );

endmodule

`default_nettype wire
